//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbExStage
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST) tests/exStageTests.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'TB PASSED' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim.f
source/exStagePkg.sv
source/exAgu.sv
source/exOpGate.sv
source/exRegWrite.sv
source/exMemIssue.sv
source/exControl.sv
source/exStage.sv
tests/exStageTb.sv

//--- source/exAgu.sv
// combinational; upper 16 bits of base and index are ignored, sum wraps at 48 bits
`timescale 1ns/10ps

module exAgu (
	input  logic [exStagePkg::dataWidth-1:0] base,
	input  logic [exStagePkg::dataWidth-1:0] index,
	input  exStagePkg::uIxtU ixt,
	output logic [exStagePkg::addrWidth-1:0] addr
);

	// index scaled by access size
	logic [exStagePkg::addrWidth-1:0] scaled;

	always_comb begin
		// size field gives 1, 2, 4 or 8 byte steps
		scaled = index[exStagePkg::addrWidth-1:0] << ixt.mem.size;
		// carry out of bit 47 is dropped
		addr = base[exStagePkg::addrWidth-1:0] + scaled;
	end

endmodule

//--- source/exControl.sv
// combinational; branch targets are 48-bit, any unknown command or sub-op holds the pipeline
`timescale 1ns/10ps

module exControl (
	input  exStagePkg::uCmdE     cmd,
	input  exStagePkg::uIxtU     ixt,
	input  exStagePkg::operandsT operands,
	input  logic [exStagePkg::addrWidth-1:0] addr,
	input  logic                 preBra,
	input  logic [63:0]          regInSr,
	input  logic [47:0]          regInLr,
	input  logic [63:0]          regInDlr,
	input  logic [63:0]          regInExc,
	input  logic                 memHold,
	output exStagePkg::crWriteT  crWrite,
	output logic [63:0]          regOutSr,
	output logic [47:0]          regOutLr,
	output logic [15:0]          trapExc,
	output logic                 exHold
);

	// branch taken and where to
	logic        doBra;
	logic [47:0] braTarget;
	// hold from this block alone
	logic        opHold;

	always_comb begin
		crWrite.id    = exStagePkg::crZero;
		crWrite.value = '0;
		regOutSr      = regInSr;
		regOutLr      = regInLr;
		trapExc       = 16'h0000;
		opHold        = 1'b0;
		doBra         = 1'b0;
		// PC-relative form keeps the PC's upper bits
		braTarget     = {operands.pc[47:32], addr[31:0]};

		case (cmd)
			exStagePkg::UCMD_NOP, exStagePkg::UCMD_LEA_MR, exStagePkg::UCMD_MOV_RM,
			exStagePkg::UCMD_MOV_MR, exStagePkg::UCMD_MOV_CR, exStagePkg::UCMD_MOV_IR: begin
				// handled by the other consumers
				opHold = 1'b0;
			end
			exStagePkg::UCMD_MOV_RC: begin
				crWrite.id    = operands.regIdRm[4:0];
				crWrite.value = operands.valRs;
			end
			exStagePkg::UCMD_BRA: begin
				// predicted branches were already taken in fetch
				doBra = !preBra;
			end
			exStagePkg::UCMD_BRA_NB: begin
				// mispredicted taken, go back to the fall-through PC
				braTarget = operands.pc;
				doBra     = preBra;
			end
			exStagePkg::UCMD_BSR: begin
				regOutLr = operands.pc;
				doBra    = !preBra;
			end
			exStagePkg::UCMD_JMP: begin
				braTarget = operands.valRs[47:0];
				doBra     = 1'b1;
			end
			exStagePkg::UCMD_JSR: begin
				regOutLr  = operands.pc;
				braTarget = operands.valRs[47:0];
				doBra     = 1'b1;
			end
			exStagePkg::UCMD_OP_IXS: begin
				// known IXS ops only write a GPR
				opHold = (ixt.sub != exStagePkg::IXS_NOP) && (ixt.sub != exStagePkg::IXS_MOVT)
					&& (ixt.sub != exStagePkg::IXS_MOVNT);
			end
			exStagePkg::UCMD_OP_IXT: begin
				case (exStagePkg::ixtE'(ixt.sub))
					exStagePkg::IXT_NOP, exStagePkg::IXT_SLEEP: opHold = 1'b0;
					// debugger armed lets BREAK through
					exStagePkg::IXT_BREAK: opHold = !regInExc[15];
					exStagePkg::IXT_CLRT:  regOutSr[0] = 1'b0;
					exStagePkg::IXT_SETT:  regOutSr[0] = 1'b1;
					exStagePkg::IXT_NOTT:  regOutSr[0] = !regInSr[0];
					exStagePkg::IXT_CLRS:  regOutSr[1] = 1'b0;
					exStagePkg::IXT_SETS:  regOutSr[1] = 1'b1;
					exStagePkg::IXT_NOTS:  regOutSr[1] = !regInSr[1];
					exStagePkg::IXT_RTE:   trapExc = exStagePkg::trapRte;
					// trap number from the Rm field
					exStagePkg::IXT_TRAPA: trapExc = {exStagePkg::trapaBase, operands.regIdRm[3:0]};
					// syscall number from DLR
					exStagePkg::IXT_SYSE:  trapExc = {exStagePkg::syseBase, regInDlr[11:0]};
					default:               opHold = 1'b1;
				endcase
			end
			// INVOP and anything undecoded
			default: opHold = 1'b1;
		endcase

		if (doBra) begin
			crWrite.id    = exStagePkg::crPc;
			crWrite.value = {16'h0000, braTarget};
		end

		exHold = opHold || memHold;
	end

endmodule

//--- source/exMemIssue.sv
// combinational; only starts a load or store, completion and data return are left to EX2
`timescale 1ns/10ps

module exMemIssue (
	input  exStagePkg::uCmdE     cmd,
	input  exStagePkg::uIxtU     ixt,
	input  exStagePkg::operandsT operands,
	input  logic [exStagePkg::addrWidth-1:0] addr,
	input  logic [1:0]           memDataOK,
	output exStagePkg::memReqT   memReq,
	output logic [5:0]           heldIdRn1,
	output logic                 regHeld,
	output logic                 memHold
);

	// a load or store goes out this cycle
	logic issue;

	always_comb begin
		memReq.addr = addr;
		memReq.data = operands.valRm;
		memReq.opm  = exStagePkg::OPM_READY;
		heldIdRn1   = exStagePkg::gprZero;
		issue       = 1'b0;

		case (cmd)
			exStagePkg::UCMD_MOV_RM: begin
				// store, data from Rm
				memReq.opm = exStagePkg::memOpmE'(exStagePkg::OPM_STORE
					| {2'b00, ixt.mem.sign, ixt.mem.size});
				issue = 1'b1;
			end
			exStagePkg::UCMD_MOV_MR: begin
				// load, Rm stays held until EX2 returns data
				memReq.opm = exStagePkg::memOpmE'(exStagePkg::OPM_LOAD
					| {2'b00, ixt.mem.sign, ixt.mem.size});
				heldIdRn1 = operands.regIdRm;
				issue     = 1'b1;
			end
			default: begin
				issue = 1'b0;
			end
		endcase

		// busy memory stalls the issuing op
		memHold = issue && (memDataOK == exStagePkg::OK_HOLD);
		regHeld = heldIdRn1 != exStagePkg::gprZero;
	end

endmodule

//--- source/exOpGate.sv
// combinational; a flush kills every op, and only a disabled BRA survives as BRA_NB
`timescale 1ns/10ps

module exOpGate (
	input  exStagePkg::uOpT  op,
	input  logic             braFlush,
	input  logic             srT,
	output exStagePkg::uCmdE cmd
);

	// condition result before the flush
	logic condOk;
	// op runs this cycle
	logic enable;

	always_comb begin
		case (op.cond)
			exStagePkg::COND_AL: condOk = 1'b1;
			exStagePkg::COND_NV: condOk = 1'b0;
			exStagePkg::COND_CT: condOk = srT;
			default:             condOk = !srT;
		endcase

		enable = condOk && !braFlush;

		if (enable) begin
			cmd = op.cmd;
		end else if ((op.cmd == exStagePkg::UCMD_BRA) && !braFlush) begin
			// not taken, later stages still see the branch
			cmd = exStagePkg::UCMD_BRA_NB;
		end else begin
			cmd = exStagePkg::UCMD_NOP;
		end
	end

endmodule

//--- source/exRegWrite.sv
// combinational; one GPR write per op, value is zero whenever the id is the null register
`timescale 1ns/10ps

module exRegWrite (
	input  exStagePkg::uCmdE     cmd,
	input  exStagePkg::uIxtU     ixt,
	input  exStagePkg::operandsT operands,
	input  logic [exStagePkg::addrWidth-1:0] addr,
	input  logic                 srT,
	output exStagePkg::gprWriteT gprWrite
);

	always_comb begin
		// no write by default
		gprWrite.id    = exStagePkg::gprZero;
		gprWrite.value = '0;

		case (cmd)
			exStagePkg::UCMD_LEA_MR: begin
				// address zero extended
				gprWrite.id    = operands.regIdRm;
				gprWrite.value = {16'h0000, addr};
			end
			exStagePkg::UCMD_MOV_CR: begin
				gprWrite.id    = operands.regIdRm;
				gprWrite.value = operands.valCRm;
			end
			exStagePkg::UCMD_MOV_IR: begin
				gprWrite.id = operands.regIdRm;
				case (ixt.sub)
					// LDI, sign from imm bit 32
					6'd0: gprWrite.value = {{31{operands.imm[32]}}, operands.imm};
					// LDISH8
					6'd1: gprWrite.value = {operands.valRs[55:0], operands.imm[7:0]};
					// LDISH16
					6'd2: gprWrite.value = {operands.valRs[47:0], operands.imm[15:0]};
					// LDISH32
					6'd3: gprWrite.value = {operands.valRs[31:0], operands.imm[31:0]};
					// JLDIX and any unknown form
					default: gprWrite.value = operands.valRt;
				endcase
			end
			exStagePkg::UCMD_OP_IXS: begin
				case (exStagePkg::ixsE'(ixt.sub))
					exStagePkg::IXS_MOVT: begin
						gprWrite.id    = operands.regIdRm;
						gprWrite.value = {63'h0, srT};
					end
					exStagePkg::IXS_MOVNT: begin
						gprWrite.id    = operands.regIdRm;
						gprWrite.value = {63'h0, !srT};
					end
					// other IXS ops write nothing here
					default: begin
						gprWrite.id = exStagePkg::gprZero;
					end
				endcase
			end
			default: begin
				gprWrite.id = exStagePkg::gprZero;
			end
		endcase
	end

endmodule

//--- source/exStage.sv
// combinational EX1 stage, no clock or reset; the caller holds inputs steady during a hold
`timescale 1ns/10ps

module exStage (
	input  exStagePkg::uOpT      op,
	input  exStagePkg::operandsT operands,
	input  logic                 braFlush,
	input  logic                 preBra,
	input  logic [63:0]          regInSr,
	input  logic [47:0]          regInLr,
	input  logic [63:0]          regInDlr,
	input  logic [63:0]          regInExc,
	input  logic [1:0]           memDataOK,
	output exStagePkg::gprWriteT gprWrite,
	output exStagePkg::crWriteT  crWrite,
	output logic [5:0]           heldIdRn1,
	output logic [63:0]          regOutSr,
	output logic [47:0]          regOutLr,
	output logic [15:0]          trapExc,
	output exStagePkg::memReqT   memReq,
	output logic [1:0]           exHold
);

	// effective command after gating
	exStagePkg::uCmdE cmd;
	logic [exStagePkg::addrWidth-1:0] aguAddr;
	logic memHold;

	exOpGate opGate (.op(op), .braFlush(braFlush), .srT(regInSr[0]), .cmd(cmd));

	// Rs is the base, Rt the index
	exAgu agu (.base(operands.valRs), .index(operands.valRt), .ixt(op.ixt), .addr(aguAddr));

	exRegWrite regWrite (.cmd(cmd), .ixt(op.ixt), .operands(operands), .addr(aguAddr),
		.srT(regInSr[0]), .gprWrite(gprWrite));

	// bit 1 of the hold marks a held destination
	exMemIssue memIssue (.cmd(cmd), .ixt(op.ixt), .operands(operands), .addr(aguAddr),
		.memDataOK(memDataOK), .memReq(memReq), .heldIdRn1(heldIdRn1),
		.regHeld(exHold[1]), .memHold(memHold));

	// bit 0 merges op holds with the memory stall
	exControl control (.cmd(cmd), .ixt(op.ixt), .operands(operands), .addr(aguAddr),
		.preBra(preBra), .regInSr(regInSr), .regInLr(regInLr), .regInDlr(regInDlr),
		.regInExc(regInExc), .memHold(memHold), .crWrite(crWrite), .regOutSr(regOutSr),
		.regOutLr(regOutLr), .trapExc(trapExc), .exHold(exHold[0]));

endmodule

//--- source/exStagePkg.sv
// code values are local to this EX1 stage and match no other decoder; widths are fixed
package exStagePkg;

	// virtual address and register widths
	localparam int addrWidth = 48;
	localparam int dataWidth = 64;

	// micro-op command codes
	typedef enum logic [5:0] {
		UCMD_NOP    = 6'h00,
		UCMD_INVOP  = 6'h01,
		UCMD_LEA_MR = 6'h02,
		UCMD_MOV_RM = 6'h03,
		UCMD_MOV_MR = 6'h04,
		UCMD_MOV_RC = 6'h05,
		UCMD_MOV_CR = 6'h06,
		UCMD_MOV_IR = 6'h07,
		UCMD_BRA    = 6'h08,
		UCMD_BRA_NB = 6'h09,
		UCMD_BSR    = 6'h0A,
		UCMD_JMP    = 6'h0B,
		UCMD_JSR    = 6'h0C,
		UCMD_OP_IXS = 6'h0D,
		UCMD_OP_IXT = 6'h0E
	} uCmdE;

	// execute conditions against SR.T
	typedef enum logic [1:0] {COND_AL, COND_NV, COND_CT, COND_CF} condE;

	// IXS sub-ops
	typedef enum logic [5:0] {IXS_NOP = 6'h00, IXS_MOVT = 6'h01, IXS_MOVNT = 6'h02} ixsE;

	// IXT sub-ops
	typedef enum logic [5:0] {
		IXT_NOP   = 6'h00,
		IXT_SLEEP = 6'h01,
		IXT_BREAK = 6'h02,
		IXT_CLRT  = 6'h03,
		IXT_SETT  = 6'h04,
		IXT_CLRS  = 6'h05,
		IXT_SETS  = 6'h06,
		IXT_NOTT  = 6'h07,
		IXT_NOTS  = 6'h08,
		IXT_RTE   = 6'h09,
		IXT_TRAPA = 6'h0A,
		IXT_SYSE  = 6'h0B
	} ixtE;

	// memory op: kind in [4:3], sign in [2], size in [1:0]
	typedef enum logic [4:0] {
		OPM_READY = 5'b00000,
		OPM_LOAD  = 5'b01000,
		OPM_STORE = 5'b10000
	} memOpmE;

	// memory status
	localparam logic [1:0] OK_READY = 2'b00;
	localparam logic [1:0] OK_OK    = 2'b01;
	localparam logic [1:0] OK_HOLD  = 2'b10;

	// null destinations and the PC control register
	localparam logic [5:0] gprZero = 6'h3F;
	localparam logic [4:0] crZero  = 5'h1F;
	localparam logic [4:0] crPc    = 5'h00;

	// trap codes, TRAPA and SYSE fill the low bits
	localparam logic [15:0] trapRte   = 16'hFF00;
	localparam logic [11:0] trapaBase = 12'hC08;
	localparam logic [3:0]  syseBase  = 4'hE;

	typedef struct packed {
		logic [1:0] size;
		logic       spare;
		logic       sign;
		logic [1:0] low;
	} memFieldsT;

	// one extension word, memory fields or a sub-op code
	typedef union packed {
		memFieldsT  mem;
		logic [5:0] sub;
	} uIxtU;

	typedef struct packed {
		condE       cond;
		uCmdE       cmd;
		logic [1:0] resv;
		uIxtU       ixt;
	} uOpT;

	typedef struct packed {
		logic [5:0]           regIdRm;
		logic [dataWidth-1:0] valRs;
		logic [dataWidth-1:0] valRt;
		logic [dataWidth-1:0] valRm;
		logic [dataWidth-1:0] valCRm;
		logic [32:0]          imm;
		logic [addrWidth-1:0] pc;
	} operandsT;

	typedef struct packed {
		logic [5:0]           id;
		logic [dataWidth-1:0] value;
	} gprWriteT;

	typedef struct packed {
		logic [4:0]           id;
		logic [dataWidth-1:0] value;
	} crWriteT;

	typedef struct packed {
		logic [addrWidth-1:0] addr;
		memOpmE               opm;
		logic [dataWidth-1:0] data;
	} memReqT;

endpackage

//--- tests/exStageTb.sv
// run from the project root; at most 64 vectors of 27 hex words each, no random stimulus
`timescale 1ns/10ps

module tbExStage;

	// vector file layout
	localparam int wordsPerVec = 27;
	localparam int maxVectors = 64;
	localparam int memDepth = 2048;
	localparam string testFile = "tests/exStageTests.txt";

	logic clock;
	logic rstN;

	// DUT inputs
	exStagePkg::uOpT      op;
	exStagePkg::operandsT operands;
	logic                 braFlush;
	logic                 preBra;
	logic [63:0]          regInSr;
	logic [47:0]          regInLr;
	logic [63:0]          regInDlr;
	logic [63:0]          regInExc;
	logic [1:0]           memDataOK;

	// DUT outputs
	exStagePkg::gprWriteT gprWrite;
	exStagePkg::crWriteT  crWrite;
	logic [5:0]           heldIdRn1;
	logic [63:0]          regOutSr;
	logic [47:0]          regOutLr;
	logic [15:0]          trapExc;
	exStagePkg::memReqT   memReq;
	logic [1:0]           exHold;

	// raw words from the file, and the vector in use
	logic [63:0] vecMem [0:memDepth-1];
	logic [63:0] cur [0:wordsPerVec-1];

	int mismatchCount;
	int otherCount;
	int vecCount;
	int vecIdx;

	exStage DUT (.op(op), .operands(operands), .braFlush(braFlush), .preBra(preBra),
		.regInSr(regInSr), .regInLr(regInLr), .regInDlr(regInDlr), .regInExc(regInExc),
		.memDataOK(memDataOK), .gprWrite(gprWrite), .crWrite(crWrite), .heldIdRn1(heldIdRn1),
		.regOutSr(regOutSr), .regOutLr(regOutLr), .trapExc(trapExc), .memReq(memReq),
		.exHold(exHold));

	// 20 ns period
	always #10 clock = ~clock;

	// marks slots the file never wrote
	function automatic logic [63:0] fillWord(input int slot);
		fillWord = {32'hF111F111, 32'(slot)};
	endfunction

	function automatic logic [63:0] memWord(input int slot);
		memWord = vecMem[11'(slot)];
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		$display("[FAIL] %0d ns vector %0d %s expected %h got %h", $time, vecIdx, name, expVal,
			actVal);
		mismatchCount++;
	endtask

	task automatic checkGpr(input exStagePkg::gprWriteT expVal, input exStagePkg::gprWriteT actVal);
		if (actVal.id !== expVal.id)
			reportMismatch("gprWrite.id", {58'h0, expVal.id}, {58'h0, actVal.id});
		if (actVal.value !== expVal.value)
			reportMismatch("gprWrite.value", expVal.value, actVal.value);
	endtask

	task automatic checkCr(input exStagePkg::crWriteT expVal, input exStagePkg::crWriteT actVal);
		if (actVal.id !== expVal.id)
			reportMismatch("crWrite.id", {59'h0, expVal.id}, {59'h0, actVal.id});
		if (actVal.value !== expVal.value)
			reportMismatch("crWrite.value", expVal.value, actVal.value);
	endtask

	task automatic checkMem(input exStagePkg::memReqT expVal, input exStagePkg::memReqT actVal);
		if (actVal.opm !== expVal.opm)
			reportMismatch("memReq.opm", {59'h0, expVal.opm}, {59'h0, actVal.opm});
		if (actVal.addr !== expVal.addr)
			reportMismatch("memReq.addr", {16'h0, expVal.addr}, {16'h0, actVal.addr});
		if (actVal.data !== expVal.data)
			reportMismatch("memReq.data", expVal.data, actVal.data);
	endtask

	task automatic checkWord64(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		if (actVal !== expVal)
			reportMismatch(name, expVal, actVal);
	endtask

	task automatic checkWord16(input string name, input logic [15:0] expVal,
		input logic [15:0] actVal);
		if (actVal !== expVal)
			reportMismatch(name, {48'h0, expVal}, {48'h0, actVal});
	endtask

	// fill, load, then count whole vectors up to the limit
	task automatic loadVectors();
		int fd;
		int base;
		logic scanning;
		fd = $fopen(testFile, "r");
		if (fd == 0) begin
			$display("cannot open the vector file %s", testFile);
			otherCount++;
		end else begin
			$fclose(fd);
			for (int slot = 0; slot < memDepth; slot++)
				vecMem[11'(slot)] = fillWord(slot);
			$readmemh(testFile, vecMem);
			scanning = 1'b1;
			while (scanning && vecCount < maxVectors) begin
				base = vecCount * wordsPerVec;
				if (memWord(base) == fillWord(base)) begin
					scanning = 1'b0;
				end else if (memWord(base + wordsPerVec - 1) == fillWord(base + wordsPerVec - 1))
					begin
					$display("vector %0d in the file is missing words", vecCount);
					otherCount++;
					scanning = 1'b0;
				end else begin
					vecCount++;
				end
			end
			if (vecCount == maxVectors) begin
				$display("vector limit of %0d reached, the rest of the file is not run", maxVectors);
				otherCount++;
			end
			if (vecCount == 0) begin
				$display("the vector file holds no complete vector");
				otherCount++;
			end
		end
	endtask

	task automatic fetchVector(input int idx);
		for (int k = 0; k < wordsPerVec; k++)
			cur[k] = memWord(idx * wordsPerVec + k);
	endtask

	// word order follows the file's columns
	task automatic driveVector();
		op                = cur[0][15:0];
		operands.regIdRm  = cur[1][5:0];
		operands.valRs    = cur[2];
		operands.valRt    = cur[3];
		operands.valRm    = cur[4];
		operands.valCRm   = cur[5];
		operands.imm      = cur[6][32:0];
		operands.pc       = cur[7][47:0];
		braFlush          = cur[8][0];
		preBra            = cur[9][0];
		regInSr           = cur[10];
		regInLr           = cur[11][47:0];
		regInDlr          = cur[12];
		regInExc          = cur[13];
		memDataOK         = cur[14][1:0];
	endtask

	task automatic checkVector();
		exStagePkg::gprWriteT expGpr;
		exStagePkg::crWriteT  expCr;
		exStagePkg::memReqT   expMem;
		expGpr.id     = cur[15][5:0];
		expGpr.value  = cur[16];
		expCr.id      = cur[17][4:0];
		expCr.value   = cur[18];
		expMem.opm    = exStagePkg::memOpmE'(cur[22][4:0]);
		expMem.addr   = cur[23][47:0];
		expMem.data   = cur[24];
		checkGpr(expGpr, gprWrite);
		checkCr(expCr, crWrite);
		checkWord64("regOutSr", cur[19], regOutSr);
		checkWord64("regOutLr", {16'h0000, cur[20][47:0]}, {16'h0000, regOutLr});
		checkWord16("trapExc", cur[21][15:0], trapExc);
		checkMem(expMem, memReq);
		checkWord16("heldIdRn1", {10'h000, cur[25][5:0]}, {10'h000, heldIdRn1});
		checkWord16("exHold", {14'h0000, cur[26][1:0]}, {14'h0000, exHold});
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		op = '0;
		operands = '0;
		braFlush = 1'b0;
		preBra = 1'b0;
		regInSr = '0;
		regInLr = '0;
		regInDlr = '0;
		regInExc = '0;
		memDataOK = exStagePkg::OK_READY;
		mismatchCount = 0;
		otherCount = 0;
		vecCount = 0;
		vecIdx = 0;
		loadVectors();
		// reset only paces the start
		repeat (2) @(posedge clock);
		#2 rstN = 1'b1;
		// bounded by the vector limit
		for (vecIdx = 0; vecIdx < vecCount; vecIdx++) begin
			@(posedge clock);
			#2;
			fetchVector(vecIdx);
			driveVector();
			// 2 ns before the next edge
			#16;
			checkVector();
		end
		$display("vectors run %0d, value mismatches %0d, file errors %0d", vecCount,
			mismatchCount, otherCount);
		if (vecCount == 0 || mismatchCount != 0 || otherCount != 0) begin
			$display("TB FAILED");
		end else begin
			$display("TB PASSED");
		end
		$finish;
	end

endmodule

//--- tests/exStageTests.txt
// in: op rmId rs rt rm crm imm pc flush preBra sr lr dlr exc memOk, all hex
// out: gprId gprVal crId crVal sr lr trap opm memAddr memData heldId hold
// condition gating and flush
0000 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
4200 5 100 10 77 55 5 400 0 0 0 300 123 0 2  3F 0 1F 0 0 300 0 0 110 77 3F 0
8600 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
C600 5 100 10 77 55 5 400 0 0 1 300 123 0 0  3F 0 1F 0 1 300 0 0 110 77 3F 0
8600 5 100 10 77 55 5 400 0 0 1 300 123 0 0  5 55 1F 0 1 300 0 0 110 77 3F 0
C600 5 100 10 77 55 5 400 0 0 0 300 123 0 0  5 55 1F 0 0 300 0 0 110 77 3F 0
0800 5 100 10 77 55 5 400 1 1 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
0300 5 100 10 77 55 5 400 1 0 0 300 123 0 2  3F 0 1F 0 0 300 0 0 110 77 3F 0
0E04 5 100 10 77 55 5 400 1 0 2 300 123 0 0  3F 0 1F 0 2 300 0 0 110 77 3F 0
4800 5 100 10 77 55 5 400 0 1 0 300 123 0 0  3F 0 0 400 0 300 0 0 110 77 3F 0
4800 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
// register writes
0230 5 100 10 77 55 5 400 0 0 0 300 123 0 0  5 180 1F 0 0 300 0 0 180 77 3F 0
0200 5 FFFFFFFFFFFFFFF0 20 77 55 5 400 0 0 0 300 123 0 0  5 10 1F 0 0 300 0 0 10 77 3F 0
0700 5 100 10 77 55 180000000 400 0 0 0 300 123 0 0  5 FFFFFFFF80000000 1F 0 0 300 0 0 110 77 3F 0
0700 5 100 10 77 55 FFFFFFFF 400 0 0 0 300 123 0 0  5 FFFFFFFF 1F 0 0 300 0 0 110 77 3F 0
0701 5 100 10 77 55 1AB 400 0 0 0 300 123 0 0  5 100AB 1F 0 0 300 0 0 110 77 3F 0
0702 5 100 10 77 55 1ABCD 400 0 0 0 300 123 0 0  5 100ABCD 1F 0 0 300 0 0 110 77 3F 0
0703 5 100 10 77 55 123456789 400 0 0 0 300 123 0 0  5 10023456789 1F 0 0 300 0 0 110 77 3F 0
0704 5 100 10 77 55 5 400 0 0 0 300 123 0 0  5 10 1F 0 0 300 0 0 110 77 3F 0
0D01 5 100 10 77 55 5 400 0 0 1 300 123 0 0  5 1 1F 0 1 300 0 0 110 77 3F 0
0D01 5 100 10 77 55 5 400 0 0 0 300 123 0 0  5 0 1F 0 0 300 0 0 110 77 3F 0
0D02 5 100 10 77 55 5 400 0 0 0 300 123 0 0  5 1 1F 0 0 300 0 0 110 77 3F 0
0D02 5 100 10 77 55 5 400 0 0 1 300 123 0 0  5 0 1F 0 1 300 0 0 110 77 3F 0
// memory issue
0324 5 100 10 77 55 5 400 0 0 0 300 123 0 1  3F 0 1F 0 0 300 0 16 140 77 3F 0
0410 5 100 10 77 55 5 400 0 0 0 300 123 0 1  3F 0 1F 0 0 300 0 9 120 77 5 2
0434 5 100 10 77 55 5 400 0 0 0 300 123 0 2  3F 0 1F 0 0 300 0 F 180 77 5 3
0300 5 100 10 77 55 5 400 0 0 0 300 123 0 2  3F 0 1F 0 0 300 0 10 110 77 3F 1
0600 5 100 10 77 55 5 400 0 0 0 300 123 0 2  5 55 1F 0 0 300 0 0 110 77 3F 0
// branches and control register writes
0800 5 500000100 10 77 55 5 123400000400 0 0 0 300 123 0 0  3F 0 0 123400000110 0 300 0 0 500000110 77 3F 0
0A00 5 100 10 77 55 5 123400000400 0 0 0 300 123 0 0  3F 0 0 123400000110 0 123400000400 0 0 110 77 3F 0
0800 5 100 10 77 55 5 123400000400 0 1 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
0A00 5 100 10 77 55 5 123400000400 0 1 0 300 123 0 0  3F 0 1F 0 0 123400000400 0 0 110 77 3F 0
0B00 5 ABCD123456789ABC 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 0 123456789ABC 0 300 0 0 123456789ACC 77 3F 0
0C00 5 ABCD123456789ABC 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 0 123456789ABC 0 400 0 0 123456789ACC 77 3F 0
0500 27 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 7 100 0 300 0 0 110 77 3F 0
// status flags and traps
0E03 5 100 10 77 55 5 400 0 0 3 300 123 0 0  3F 0 1F 0 2 300 0 0 110 77 3F 0
0E04 5 100 10 77 55 5 400 0 0 2 300 123 0 0  3F 0 1F 0 3 300 0 0 110 77 3F 0
0E07 5 100 10 77 55 5 400 0 0 3 300 123 0 0  3F 0 1F 0 2 300 0 0 110 77 3F 0
0E05 5 100 10 77 55 5 400 0 0 3 300 123 0 0  3F 0 1F 0 1 300 0 0 110 77 3F 0
0E06 5 100 10 77 55 5 400 0 0 1 300 123 0 0  3F 0 1F 0 3 300 0 0 110 77 3F 0
0E08 5 100 10 77 55 5 400 0 0 1 300 123 0 0  3F 0 1F 0 3 300 0 0 110 77 3F 0
0E09 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 FF00 0 110 77 3F 0
0E0A 1B 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 C08B 0 110 77 3F 0
0E0B 5 100 10 77 55 5 400 0 0 0 300 ABC1234 0 0  3F 0 1F 0 0 300 E234 0 110 77 3F 0
// holds
0100 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 1
0F00 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 1
0D05 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 1
0E0F 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 1
0E02 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 1
0E02 5 100 10 77 55 5 400 0 0 0 300 123 8000 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
0E01 5 100 10 77 55 5 400 0 0 0 300 123 0 0  3F 0 1F 0 0 300 0 0 110 77 3F 0
